/* rtl/pool_cfg_pkg.sv */
package pool_cfg_pkg;

    // Input map and kernel geometry
    localparam int IFM_SIZE      = 10;
    localparam int POOL_K        = 2;    // Kernel side, also the stride
    localparam int IFM_SIZE_NEXT = (IFM_SIZE - POOL_K) / POOL_K + 1;

    localparam int IFM_PIXELS    = IFM_SIZE * IFM_SIZE;
    localparam int NEXT_PIXELS   = IFM_SIZE_NEXT * IFM_SIZE_NEXT;

    // Two horizontally adjacent pixels come back per read
    localparam int PAIRS_PER_ROW = IFM_SIZE / 2;

    // Reading may stall here, first pair of the first odd row
    localparam int HOLD_ADDR     = IFM_SIZE;

    localparam int NUM_BANKS     = 3;    // Output banks in rotation

    localparam int RD_ADDR_W     = $clog2(IFM_PIXELS);
    localparam int WR_ADDR_W     = $clog2(NEXT_PIXELS);
    localparam int PIX_W         = 16;

endpackage

/* rtl/pool_types_pkg.sv */
package pool_types_pkg;
    import pool_cfg_pkg::*;

    // Feature map pixel, two's complement
    typedef logic signed [PIX_W-1:0] pixel_t;

    // One read returns both pixels of a horizontal pair
    typedef struct packed {
        pixel_t left;   // Even address
        pixel_t right;  // Odd address
    } pix_pair_t;

    typedef logic [RD_ADDR_W-1:0] rd_addr_t;

    typedef logic [WR_ADDR_W-1:0] wr_addr_t;

    typedef logic [$clog2(NUM_BANKS)-1:0] bank_sel_t;

endpackage

/* rtl/pool_stream_if.sv */
`timescale 1ns/10ps

// No ready signal, consumers always take the item
interface pool_stream_if #(
    parameter type T = logic
);
    logic valid;    // One cycle per item
    T     data;
    logic row_end;  // Last item of a row
    logic map_end;  // Last item of the map

    modport producer (
        output valid,
        output data,
        output row_end,
        output map_end
    );

    modport consumer (
        input valid,
        input data,
        input row_end,
        input map_end
    );

endinterface

/* rtl/pool_ctrl.sv */
`timescale 1ns/10ps

module pool_ctrl
    import pool_cfg_pkg::*, pool_types_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             start_from_previous,
    input  logic             conv_ready,
    input  logic             bank_full,
    output logic             end_to_previous,
    output logic             rd_en,
    output rd_addr_t         rd_addr_a,
    output rd_addr_t         rd_addr_b,
    pool_stream_if.producer  pair_s,
    input  pixel_t           rd_data_a,
    input  pixel_t           rd_data_b
);

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        READ   = 2'b01,
        FINISH = 2'b10,
        HOLD   = 2'b11
    } state_t;

    state_t state, state_next;

    logic [$clog2(PAIRS_PER_ROW)-1:0] pair_col;   // Pair position within the row
    logic at_hold;
    logic stall;
    logic last_pair;
    logic row_last;

    assign at_hold   = (rd_addr_a == rd_addr_t'(HOLD_ADDR));
    assign stall     = at_hold && (bank_full || !conv_ready);
    assign last_pair = (rd_addr_a == rd_addr_t'(IFM_PIXELS - 2));
    assign row_last  = (pair_col == PAIRS_PER_ROW - 1);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            state <= IDLE;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next      = state;
        rd_en           = 1'b0;
        end_to_previous = 1'b0;

        case (state)
            IDLE, FINISH:
            begin
                end_to_previous = 1'b1;
                if (start_from_previous)
                    state_next = READ;
            end
            READ:
            begin
                // Pause before the hold address goes out
                if (stall)
                    state_next = HOLD;
                else
                begin
                    rd_en = 1'b1;
                    if (last_pair)
                        state_next = FINISH;
                end
            end
            HOLD:
            begin
                if (!bank_full && conv_ready)
                    state_next = READ;
            end
            default:
                state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            rd_addr_a <= '0;
            pair_col  <= '0;
        end
        else if (rd_en)
        begin
            rd_addr_a <= last_pair ? '0 : rd_addr_a + 2'd2;
            pair_col  <= row_last ? '0 : pair_col + 1'b1;
        end
    end

    assign rd_addr_b = rd_en ? rd_addr_a + 1'b1 : '0;  // Odd pixel of the pair

    // Markers follow the read by one cycle, in step with the memory data
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pair_s.valid   <= 1'b0;
            pair_s.row_end <= 1'b0;
            pair_s.map_end <= 1'b0;
        end
        else
        begin
            pair_s.valid   <= rd_en;
            pair_s.row_end <= rd_en && row_last;
            pair_s.map_end <= rd_en && last_pair;
        end
    end

    assign pair_s.data = pix_pair_t'{left: rd_data_a, right: rd_data_b};

endmodule

/* rtl/pool_window.sv */
`timescale 1ns/10ps

module pool_window
    import pool_cfg_pkg::*, pool_types_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    pool_stream_if.consumer  pair_s,
    pool_stream_if.producer  pool_s
);

    pixel_t    line_buf [PAIRS_PER_ROW];   // Even row pair maxima
    pix_pair_t pair_in;
    pixel_t    pair_max;
    logic      odd_row;
    logic      emit;

    logic [$clog2(PAIRS_PER_ROW)-1:0] pair_idx;

    function automatic pixel_t max_pix(input pixel_t a, input pixel_t b);
        return (a > b) ? a : b;
    endfunction

    assign pair_in  = pair_s.data;
    assign pair_max = max_pix(pair_in.left, pair_in.right);
    assign emit     = pair_s.valid && odd_row;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            odd_row  <= 1'b0;
            pair_idx <= '0;
        end
        else if (pair_s.valid)
        begin
            if (pair_s.row_end)
            begin
                // Map end brings the parity back to an even row
                odd_row  <= !odd_row && !pair_s.map_end;
                pair_idx <= '0;
            end
            else
                pair_idx <= pair_idx + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pair_s.valid && !odd_row)
            line_buf[pair_idx] <= pair_max;
    end

    // Vertical max against the buffered row
    always_ff @(posedge clk)
    begin
        if (emit)
            pool_s.data <= max_pix(line_buf[pair_idx], pair_max);
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            pool_s.valid   <= 1'b0;
            pool_s.row_end <= 1'b0;
            pool_s.map_end <= 1'b0;
        end
        else
        begin
            pool_s.valid   <= emit;
            pool_s.row_end <= emit && pair_s.row_end;
            pool_s.map_end <= emit && pair_s.map_end;
        end
    end

endmodule

/* rtl/pool_writeback.sv */
`timescale 1ns/10ps

module pool_writeback
    import pool_cfg_pkg::*, pool_types_pkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             end_from_next,
    pool_stream_if.consumer  pool_s,
    output logic             wr_en,
    output wr_addr_t         wr_addr,
    output pixel_t           wr_data,
    output logic             start_to_next,
    output bank_sel_t        bank_sel,
    output logic             bank_full
);

    logic wr_last;   // Current write closes the map

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            wr_en   <= 1'b0;
            wr_last <= 1'b0;
        end
        else
        begin
            wr_en   <= pool_s.valid;
            wr_last <= pool_s.valid && pool_s.map_end;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pool_s.valid)
            wr_data <= pool_s.data;
    end

    // Address of the write in progress, moves on after it
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            wr_addr <= '0;
        else if (wr_en)
        begin
            if (wr_last || wr_addr == wr_addr_t'(NEXT_PIXELS - 1))
                wr_addr <= '0;
            else
                wr_addr <= wr_addr + 1'b1;
        end
    end

    assign start_to_next = bank_full && end_from_next;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            bank_full <= 1'b0;
            bank_sel  <= '0;
        end
        else
        begin
            if (wr_en && wr_last)
                bank_full <= 1'b1;
            else if (start_to_next)
                bank_full <= 1'b0;

            if (start_to_next)
                bank_sel <= (bank_sel == bank_sel_t'(NUM_BANKS - 1)) ? '0 : bank_sel + 1'b1;
        end
    end

endmodule

/* rtl/pool_layer_top.sv */
`timescale 1ns/10ps

module pool_layer_top
    import pool_types_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start_from_previous,
    input  logic       conv_ready,
    input  logic       end_from_next,
    input  pixel_t     rd_data_a,
    input  pixel_t     rd_data_b,
    output logic       end_to_previous,
    output logic       rd_en,
    output rd_addr_t   rd_addr_a,
    output rd_addr_t   rd_addr_b,
    output logic       wr_en,
    output wr_addr_t   wr_addr,
    output pixel_t     wr_data,
    output logic       start_to_next,
    output bank_sel_t  bank_sel
);

    logic bank_full;   // Output bank not yet released by the next layer

    pool_stream_if #(.T(pix_pair_t)) pair_s ();
    pool_stream_if #(.T(pixel_t))    pool_s ();

    pool_ctrl u_ctrl (
        .clk                 (clk),
        .reset               (reset),
        .start_from_previous (start_from_previous),
        .conv_ready          (conv_ready),
        .bank_full           (bank_full),
        .end_to_previous     (end_to_previous),
        .rd_en               (rd_en),
        .rd_addr_a           (rd_addr_a),
        .rd_addr_b           (rd_addr_b),
        .pair_s              (pair_s.producer),
        .rd_data_a           (rd_data_a),
        .rd_data_b           (rd_data_b)
    );

    pool_window u_window (
        .clk    (clk),
        .reset  (reset),
        .pair_s (pair_s.consumer),
        .pool_s (pool_s.producer)
    );

    pool_writeback u_writeback (
        .clk           (clk),
        .reset         (reset),
        .end_from_next (end_from_next),
        .pool_s        (pool_s.consumer),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .start_to_next (start_to_next),
        .bank_sel      (bank_sel),
        .bank_full     (bank_full)
    );

endmodule

/* tb/pool_layer_chk.sv */
`timescale 1ns/10ps

module pool_layer_chk
    import pool_types_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     rd_en,
    input  rd_addr_t rd_addr_a,
    input  rd_addr_t rd_addr_b,
    input  logic     end_to_previous,
    input  logic     start_to_next,
    input  logic     end_from_next
);

    // Both pixels of a pair come from neighbouring addresses
    rd_pair_adjacent: assert property (
        @(posedge clk) disable iff (reset)
        rd_en |-> (rd_addr_b == rd_addr_a + 1'b1)
    ) else $error("rd_addr_b is not rd_addr_a plus one during a read");

    rd_only_when_busy: assert property (
        @(posedge clk) disable iff (reset)
        rd_en |-> !end_to_previous
    ) else $error("read issued while end_to_previous is high");

    start_single_cycle: assert property (
        @(posedge clk) disable iff (reset)
        start_to_next |=> !start_to_next
    ) else $error("start_to_next held for more than one cycle");

    // Next layer must have signalled it is done
    start_after_release: assert property (
        @(posedge clk) disable iff (reset)
        start_to_next |-> end_from_next
    ) else $error("start_to_next pulsed while end_from_next is low");

endmodule

/* tb/tb_pool_layer.sv */
`timescale 1ns/10ps

module tb_pool_layer
    import pool_cfg_pkg::*, pool_types_pkg::*;
();

    typedef struct packed {
        int start_delay;   // Cycles before start_from_previous
        int conv_low;      // Cycles with conv_ready held low
        int end_delay;     // Cycles from last write to end_from_next
    } map_step_t;

    localparam int NUM_MAPS = 6;
    localparam map_step_t STEPS [NUM_MAPS] = '{
        '{3, 0, 2},
        '{0, 20, 0},
        '{5, 0, 40},    // Next map stalls on the unreleased bank
        '{0, 0, 0},
        '{0, 12, 60},
        '{2, 0, 5}
    };

    logic      clk;
    logic      reset;
    logic      start_from_previous;
    logic      conv_ready;
    logic      end_from_next;
    pixel_t    rd_data_a;
    pixel_t    rd_data_b;
    logic      end_to_previous;
    logic      rd_en;
    rd_addr_t  rd_addr_a;
    rd_addr_t  rd_addr_b;
    logic      wr_en;
    wr_addr_t  wr_addr;
    pixel_t    wr_data;
    logic      start_to_next;
    bank_sel_t bank_sel;

    pixel_t      mem [IFM_PIXELS];   // External input buffer
    logic [31:0] lfsr_state;
    pixel_t      exp_pix_q [$];
    wr_addr_t    exp_addr_q [$];
    int          odd_rd_q [$];       // Cycles of odd-row reads
    rd_addr_t    exp_rd_addr = '0;
    int          cycle = 0;
    int          reads_total = 0;
    int          stall_cycles = 0;
    int          starts_seen = 0;
    int          done_maps = 0;
    logic        bank_busy = 1'b0;
    logic        held_prev = 1'b0;
    logic        stall_prev = 1'b0;
    logic        map_busy = 1'b0;    // Between first and last read of a map
    logic        last_read_prev = 1'b0;
    logic        stall_now;
    logic        at_hold;
    string       summary;

    pool_layer_top dut (.*);

    bind pool_layer_top pool_layer_chk u_chk (
        .clk             (clk),
        .reset           (reset),
        .rd_en           (rd_en),
        .rd_addr_a       (rd_addr_a),
        .rd_addr_b       (rd_addr_b),
        .end_to_previous (end_to_previous),
        .start_to_next   (start_to_next),
        .end_from_next   (end_from_next)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int timeout_limit();
        int max_start;
        int max_conv;
        int max_end;
        max_start = 0;
        max_conv  = 0;
        max_end   = 0;
        for (int i = 0; i < NUM_MAPS; i++)
        begin
            if (STEPS[i].start_delay > max_start) max_start = STEPS[i].start_delay;
            if (STEPS[i].conv_low > max_conv) max_conv = STEPS[i].conv_low;
            if (STEPS[i].end_delay > max_end) max_end = STEPS[i].end_delay;
        end
        return NUM_MAPS * (50 + 25 + max_start + max_conv + max_end) + 200;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string name, input int exp, input int got);
        fail_run($sformatf("error at %0t ns: %s expected %0d, got %0d", $time, name, exp, got));
    endtask

    task automatic check_pixel(input string name, input pixel_t exp, input pixel_t got);
        if (got !== exp) report_mismatch(name, exp, got);
    endtask

    task automatic check_wr_addr(input string name, input wr_addr_t exp, input wr_addr_t got);
        if (got !== exp) report_mismatch(name, exp, got);
    endtask

    task automatic check_rd_addr(input string name, input rd_addr_t exp, input rd_addr_t got);
        if (got !== exp) report_mismatch(name, exp, got);
    endtask

    task automatic check_bank(input string name, input bank_sel_t exp, input bank_sel_t got);
        if (got !== exp) report_mismatch(name, exp, got);
    endtask

    task automatic verify_flag(input string name, input logic exp, input logic got);
        if (got !== exp) report_mismatch(name, exp, got);
    endtask

    task automatic verify_latency(input string name, input int exp, input int got);
        if (got != exp) report_mismatch(name, exp, got);
    endtask

    // New random map, then the expected 5x5 maxima in row-major order
    task automatic fill_map();
        pixel_t pix;
        pixel_t win;
        int     base;
        for (int i = 0; i < IFM_PIXELS; i++)
        begin
            for (int b = 0; b < PIX_W; b++)
            begin
                lfsr_state = lfsr_next(lfsr_state);
                pix[b] = lfsr_state[0];
            end
            mem[i] = pix;
        end
        for (int oy = 0; oy < IFM_SIZE_NEXT; oy++)
            for (int ox = 0; ox < IFM_SIZE_NEXT; ox++)
            begin
                base = oy * POOL_K * IFM_SIZE + ox * POOL_K;
                win  = mem[base];
                for (int dy = 0; dy < POOL_K; dy++)
                    for (int dx = 0; dx < POOL_K; dx++)
                        if (mem[base + dy * IFM_SIZE + dx] > win)
                            win = mem[base + dy * IFM_SIZE + dx];
                exp_pix_q.push_back(win);
                exp_addr_q.push_back(wr_addr_t'(oy * IFM_SIZE_NEXT + ox));
            end
    endtask

    // Synchronous read port of the buffer
    always @(posedge clk)
    begin
        if (rd_en)
        begin
            rd_data_a <= mem[rd_addr_a];
            rd_data_b <= mem[rd_addr_b];
        end
    end

    // Next layer, releases each bank after its delay
    initial
    begin
        end_from_next = 1'b0;
        forever
        begin
            @(posedge clk);
            while (!(wr_en && wr_addr == wr_addr_t'(NEXT_PIXELS - 1)))
                @(posedge clk);
            repeat (STEPS[done_maps].end_delay) @(posedge clk);
            end_from_next <= 1'b1;
            @(posedge clk);
            while (!start_to_next)
                @(posedge clk);
            end_from_next <= 1'b0;
            done_maps++;
        end
    end

    always @(posedge clk)
    begin
        cycle = cycle + 1;
        if (cycle > timeout_limit())
            fail_run($sformatf("timeout: the run did not finish within %0d cycles", cycle - 1));
        if (!reset)
        begin
            // Low through the whole map, stalls included
            if (map_busy)
                verify_flag("end_to_previous", 1'b0, end_to_previous);
            if (last_read_prev)
                verify_flag("end_to_previous", 1'b1, end_to_previous);

            // Hold point, READ then HOLD while stalled, one idle cycle to resume
            stall_now = !conv_ready || bank_busy;
            at_hold   = map_busy && rd_addr_a == rd_addr_t'(HOLD_ADDR);
            if (at_hold)
            begin
                verify_flag("rd_en", !stall_now && !(held_prev && stall_prev), rd_en);
                if (!rd_en) stall_cycles++;
            end
            held_prev  = at_hold && !rd_en;
            stall_prev = stall_now;

            last_read_prev = rd_en && exp_rd_addr == rd_addr_t'(IFM_PIXELS - 2);
            if (rd_en)
            begin
                check_rd_addr("rd_addr_a", exp_rd_addr, rd_addr_a);
                check_rd_addr("rd_addr_b", exp_rd_addr + 1'b1, rd_addr_b);
                verify_flag("end_to_previous", 1'b0, end_to_previous);
                if ((rd_addr_a / IFM_SIZE) % 2 == 1)
                    odd_rd_q.push_back(cycle);
                map_busy    = !last_read_prev;
                exp_rd_addr = last_read_prev ? '0 : exp_rd_addr + 2'd2;
                reads_total++;
            end

            if (wr_en)
            begin
                if (exp_pix_q.size() == 0 || odd_rd_q.size() == 0)
                    fail_run("a write arrived with no expected result pending");
                check_wr_addr("wr_addr", exp_addr_q.pop_front(), wr_addr);
                check_pixel("wr_data", exp_pix_q.pop_front(), wr_data);
                verify_latency("wr_en latency", 3, cycle - odd_rd_q.pop_front());
            end

            if (start_to_next)
            begin
                if (!bank_busy)
                    fail_run("start_to_next pulsed while no output bank was full");
                check_bank("bank_sel", bank_sel_t'(starts_seen % NUM_BANKS), bank_sel);
                starts_seen++;
            end

            if (wr_en && wr_addr == wr_addr_t'(NEXT_PIXELS - 1))
                bank_busy = 1'b1;
            else if (start_to_next)
                bank_busy = 1'b0;
        end
    end

    initial
    begin
        reset               = 1'b1;
        start_from_previous = 1'b0;
        conv_ready          = 1'b1;
        rd_data_a           = '0;
        rd_data_b           = '0;
        lfsr_state          = 32'd94039;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        verify_flag("end_to_previous", 1'b1, end_to_previous);
        verify_flag("rd_en", 1'b0, rd_en);
        verify_flag("wr_en", 1'b0, wr_en);
        verify_flag("start_to_next", 1'b0, start_to_next);
        check_rd_addr("rd_addr_a", '0, rd_addr_a);
        check_wr_addr("wr_addr", '0, wr_addr);
        check_bank("bank_sel", '0, bank_sel);

        for (int m = 0; m < NUM_MAPS; m++)
        begin
            while (!end_to_previous)
                @(posedge clk);
            fill_map();
            repeat (STEPS[m].start_delay) @(posedge clk);
            start_from_previous <= 1'b1;
            if (STEPS[m].conv_low > 0)
                conv_ready <= 1'b0;
            @(posedge clk);
            start_from_previous <= 1'b0;
            repeat (STEPS[m].conv_low) @(posedge clk);
            conv_ready <= 1'b1;
            @(posedge clk);
        end

        while (starts_seen < NUM_MAPS)
            @(posedge clk);
        repeat (4) @(posedge clk);
        check_bank("bank_sel", '0, bank_sel);

        summary = "";
        if (reads_total != NUM_MAPS * PAIRS_PER_ROW * IFM_SIZE)
            summary = $sformatf("expected %0d reads in total but saw %0d",
                                NUM_MAPS * PAIRS_PER_ROW * IFM_SIZE, reads_total);
        else if (exp_pix_q.size() != 0)
            summary = "some expected output writes never happened";
        else if (stall_cycles == 0)
            summary = "reading never paused at the hold point";

        if (summary != "")
            fail_run(summary);
        else
        begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

/* flist.f */
rtl/pool_cfg_pkg.sv
rtl/pool_types_pkg.sv
rtl/pool_stream_if.sv
rtl/pool_ctrl.sv
rtl/pool_window.sv
rtl/pool_writeback.sv
rtl/pool_layer_top.sv
tb/pool_layer_chk.sv
tb/tb_pool_layer.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := tb_pool_layer
FLIST     := flist.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP)

clean:
	rm -rf $(OBJ_DIR)
